// ==== hw/fir_defines.svh ====
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Tap address width, the filter has 2**FIR_ADDR_WIDTH taps
`define FIR_ADDR_WIDTH 4

// Beat slots in the FIFO, also the credits the producer starts with
`define FIR_FIFO_DEPTH 4

// Input sample width
`define FIR_SAMPLE_W 16

// Coefficient width
`define FIR_COEFF_W 16

// Accumulator width, the sum wraps modulo 2**FIR_ACC_W
`define FIR_ACC_W 32

// Sequence tag width
`define FIR_SEQ_W 8

`endif

// ==== hw/fir_pkg.sv ====
`include "fir_defines.svh"

package fir_pkg;

  // Data widths
  typedef logic [`FIR_SAMPLE_W-1:0]   sample_t;
  typedef logic [`FIR_COEFF_W-1:0]    coeff_t;
  typedef logic [`FIR_ACC_W-1:0]      acc_t;
  typedef logic [`FIR_ADDR_WIDTH-1:0] tap_addr_t;
  typedef logic [`FIR_SEQ_W-1:0]      seq_t;

  // FIFO slot index
  typedef logic [$clog2(`FIR_FIFO_DEPTH)-1:0] fifo_ptr_t;

  // Needs to hold the full depth, not just depth-1
  typedef logic [$clog2(`FIR_FIFO_DEPTH+1)-1:0] credit_t;

  // Tagged sample, producer -> FIFO -> engine
  typedef struct packed {
    sample_t sample;
    seq_t    seq;
  } sample_beat_t;

  // One filter output
  typedef struct packed {
    acc_t    y;
    sample_t oldest;
    seq_t    seq;
  } fir_result_t;

  // MAC engine states
  typedef enum logic [2:0] {
    CLEAR,
    IDLE,
    PRIME,
    ACCUM,
    DRAIN,
    EMIT
  } mac_state_t;

endpackage

// ==== hw/fir_dpram.sv ====
`timescale 1ns/1ps

module fir_dpram #(
  parameter int unsigned Depth = 16,
  parameter type data_t = logic [15:0]
) (
  input  logic                     clk_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] waddr_i,
  input  data_t                    wdata_i,
  input  logic                     re_i,
  input  logic [$clog2(Depth)-1:0] raddr_i,
  output data_t                    rdata_o
);

  data_t mem [0:Depth-1];
  data_t rdata_q;

  // Write port
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // Registered read, data shows up one cycle after re_i
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_q <= mem[raddr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/fir_sample_source.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_sample_source (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  sample_valid_i,
  input  fir_pkg::sample_t      sample_i,
  input  logic                  credit_return_i,
  output logic                  sample_ready_o,
  output logic                  beat_push_o,
  output fir_pkg::sample_beat_t beat_o
);

  import fir_pkg::*;

  credit_t      credits_q;
  seq_t         seq_q;
  logic         accept;
  logic         push_q;
  sample_beat_t beat_q;

  // Only take a sample while the FIFO is known to have room
  assign sample_ready_o = (credits_q != '0);
  assign accept         = sample_valid_i && sample_ready_o;

  // Credit taken at acceptance, so ready drops before the push lands
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q <= credit_t'(`FIR_FIFO_DEPTH);
    end else if (accept && !credit_return_i) begin
      credits_q <= credits_q - 1'b1;
    end else if (!accept && credit_return_i) begin
      credits_q <= credits_q + 1'b1;
    end
  end

  // Tag counter and push strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q  <= '0;
      push_q <= 1'b0;
    end else begin
      push_q <= accept;
      if (accept) begin
        seq_q <= seq_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_q.sample <= sample_i;
      beat_q.seq    <= seq_q;
    end
  end

  assign beat_push_o = push_q;
  assign beat_o      = beat_q;

endmodule

// ==== hw/fir_sample_fifo.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_sample_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push_i,
  input  fir_pkg::sample_beat_t beat_i,
  input  logic                  pop_i,
  output logic                  beat_valid_o,
  output fir_pkg::sample_beat_t beat_o,
  output logic                  credit_o
);

  import fir_pkg::*;

  localparam int unsigned Depth = `FIR_FIFO_DEPTH;

  sample_beat_t mem [0:Depth-1];
  fifo_ptr_t    wr_ptr_q;
  fifo_ptr_t    rd_ptr_q;
  credit_t      count_q;
  logic         full;
  logic         push_en;
  logic         pop_en;
  logic         credit_q;

  assign full         = (count_q == credit_t'(Depth));
  assign beat_valid_o = (count_q != '0);
  assign push_en      = push_i && !full;
  assign pop_en       = pop_i && beat_valid_o;

  // Head is visible combinationally, consumer reads it in the pop cycle
  assign beat_o = mem[rd_ptr_q];

  // Wrap explicitly in case the depth is not a power of two
  function automatic fifo_ptr_t ptr_next(fifo_ptr_t ptr);
    if (ptr == fifo_ptr_t'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr_q] <= beat_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      credit_q <= pop_en;
      if (push_en) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      // Occupancy, simultaneous push and pop leave it alone
      if (push_en && !pop_en) begin
        count_q <= count_q + 1'b1;
      end else if (pop_en && !push_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // One credit back to the producer per popped beat
  assign credit_o = credit_q;

endmodule

// ==== hw/fir_mac_engine.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module fir_mac_engine (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  beat_valid_i,
  input  fir_pkg::sample_beat_t beat_i,
  output logic                  beat_pop_o,
  input  logic                  coef_we_i,
  input  fir_pkg::tap_addr_t    coef_addr_i,
  input  fir_pkg::coeff_t       coef_data_i,
  output logic                  result_valid_o,
  output fir_pkg::fir_result_t  result_o
);

  import fir_pkg::*;

  localparam int unsigned NumTaps = 2 ** `FIR_ADDR_WIDTH;
  localparam tap_addr_t   LastTap = tap_addr_t'(NumTaps - 1);

  mac_state_t state_q;
  mac_state_t state_d;

  // Circular history pointers and tap counter
  tap_addr_t wr_ptr_q;
  tap_addr_t rd_ptr_q;
  tap_addr_t tap_cnt_q;

  logic      sample_we;
  sample_t   sample_wdata;
  logic      mac_re;
  logic      rd_vld_q;
  sample_t   rd_sample;
  coeff_t    rd_coeff;
  acc_t      product;

  acc_t      acc_q;
  sample_t   oldest_q;
  seq_t      seq_q;

  assign beat_pop_o = (state_q == IDLE) && beat_valid_i;

  // Zero fill during CLEAR, otherwise the popped sample
  assign sample_we    = (state_q == CLEAR) || beat_pop_o;
  assign sample_wdata = (state_q == CLEAR) ? '0 : beat_i.sample;

  // Both RAMs are read together, one tap per ACCUM cycle
  assign mac_re = (state_q == ACCUM);

  fir_dpram #(
    .Depth  (NumTaps),
    .data_t (sample_t)
  ) sample_ram (
    .clk_i   (clk_i),
    .we_i    (sample_we),
    .waddr_i (wr_ptr_q),
    .wdata_i (sample_wdata),
    .re_i    (mac_re),
    .raddr_i (rd_ptr_q),
    .rdata_o (rd_sample)
  );

  fir_dpram #(
    .Depth  (NumTaps),
    .data_t (coeff_t)
  ) coeff_ram (
    .clk_i   (clk_i),
    .we_i    (coef_we_i),
    .waddr_i (coef_addr_i),
    .wdata_i (coef_data_i),
    .re_i    (mac_re),
    .raddr_i (tap_cnt_q),
    .rdata_o (rd_coeff)
  );

  // Widen before multiplying so the full 32-bit product survives
  assign product = acc_t'(rd_sample) * acc_t'(rd_coeff);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      CLEAR: begin
        if (wr_ptr_q == LastTap) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (beat_valid_i) begin
          state_d = PRIME;
        end
      end
      PRIME: state_d = ACCUM;
      ACCUM: begin
        if (tap_cnt_q == LastTap) begin
          state_d = DRAIN;
        end
      end
      DRAIN: state_d = EMIT;
      EMIT:  state_d = IDLE;
      default: state_d = CLEAR;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= CLEAR;
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      tap_cnt_q <= '0;
      rd_vld_q  <= 1'b0;
    end else begin
      state_q  <= state_d;
      rd_vld_q <= mac_re;
      if (sample_we) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      // Newest sample first, then walk back in time
      if (beat_pop_o) begin
        rd_ptr_q  <= wr_ptr_q;
        tap_cnt_q <= '0;
      end else if (mac_re) begin
        rd_ptr_q  <= rd_ptr_q - 1'b1;
        tap_cnt_q <= tap_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_pop_o) begin
      seq_q <= beat_i.seq;
    end
    if (state_q == PRIME) begin
      acc_q <= '0;
    end else if (rd_vld_q) begin
      acc_q <= acc_q + product;
    end
    // Last tap lands in DRAIN, that read is the oldest sample in the window
    if (state_q == DRAIN) begin
      oldest_q <= rd_sample;
    end
  end

  assign result_valid_o  = (state_q == EMIT);
  assign result_o.y      = acc_q;
  assign result_o.oldest = oldest_q;
  assign result_o.seq    = seq_q;

endmodule

// ==== hw/fir_top.sv ====
`timescale 1ns/1ps

module fir_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 sample_valid_i,
  input  fir_pkg::sample_t     sample_i,
  output logic                 sample_ready_o,
  input  logic                 coef_we_i,
  input  fir_pkg::tap_addr_t   coef_addr_i,
  input  fir_pkg::coeff_t      coef_data_i,
  output logic                 result_valid_o,
  output fir_pkg::fir_result_t result_o
);

  import fir_pkg::*;

  // Producer to FIFO
  logic         beat_push;
  sample_beat_t beat;
  logic         credit_return;

  // FIFO to engine
  logic         beat_valid;
  sample_beat_t head_beat;
  logic         beat_pop;

  fir_sample_source source_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sample_valid_i  (sample_valid_i),
    .sample_i        (sample_i),
    .credit_return_i (credit_return),
    .sample_ready_o  (sample_ready_o),
    .beat_push_o     (beat_push),
    .beat_o          (beat)
  );

  fir_sample_fifo fifo_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (beat_push),
    .beat_i       (beat),
    .pop_i        (beat_pop),
    .beat_valid_o (beat_valid),
    .beat_o       (head_beat),
    .credit_o     (credit_return)
  );

  fir_mac_engine engine_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .beat_valid_i   (beat_valid),
    .beat_i         (head_beat),
    .beat_pop_o     (beat_pop),
    .coef_we_i      (coef_we_i),
    .coef_addr_i    (coef_addr_i),
    .coef_data_i    (coef_data_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

endmodule

// ==== tests/tb_fir_top.sv ====
`timescale 1ns/1ps
`include "fir_defines.svh"

module tb_fir_top;

  import fir_pkg::*;

  localparam int unsigned NumTaps   = 2 ** `FIR_ADDR_WIDTH;
  localparam int unsigned WaitLimit = 500;

  logic        clk_i;
  logic        rst_ni;
  logic        sample_valid_i;
  sample_t     sample_i;
  logic        sample_ready_o;
  logic        coef_we_i;
  tap_addr_t   coef_addr_i;
  coeff_t      coef_data_i;
  logic        result_valid_o;
  fir_result_t result_o;

  // Reference model state
  int          seed = 64427;
  coeff_t      coefs [NumTaps];
  sample_t     hist [NumTaps];
  seq_t        next_seq;
  fir_result_t expected_q [$];
  fir_result_t exp_res;
  logic        saw_stall;

  fir_top dut_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sample_valid_i (sample_valid_i),
    .sample_i       (sample_i),
    .sample_ready_o (sample_ready_o),
    .coef_we_i      (coef_we_i),
    .coef_addr_i    (coef_addr_i),
    .coef_data_i    (coef_data_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o)
  );

  always #5 clk_i = ~clk_i;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("filter sum does not match the model");
    end
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("oldest sample does not match the model");
    end
  endtask

  task automatic check_seq(input string name, input seq_t got, input seq_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run("sequence tag does not match the model");
    end
  endtask

  // Shift the sample in and queue the expected output
  task automatic record_accept(input sample_t s);
    acc_t        sum;
    fir_result_t res;
    for (int i = NumTaps - 1; i > 0; i--) begin
      hist[i] = hist[i - 1];
    end
    hist[0] = s;
    sum = '0;
    for (int k = 0; k < NumTaps; k++) begin
      sum = sum + acc_t'(hist[k]) * acc_t'(coefs[k]);
    end
    res.y      = sum;
    res.oldest = hist[NumTaps - 1];
    res.seq    = next_seq;
    expected_q.push_back(res);
    next_seq = next_seq + 1'b1;
  endtask

  task automatic load_coef(input tap_addr_t addr, input coeff_t data);
    @(posedge clk_i);
    coef_we_i   <= 1'b1;
    coef_addr_i <= addr;
    coef_data_i <= data;
    coefs[addr] = data;
    @(posedge clk_i);
    coef_we_i <= 1'b0;
  endtask

  task automatic load_all_coefs(input bit all_ones);
    for (int a = 0; a < NumTaps; a++) begin
      load_coef(tap_addr_t'(a), all_ones ? coeff_t'(1) : coeff_t'($random(seed)));
    end
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_sample(input sample_t s);
    int waited;
    sample_valid_i <= 1'b1;
    sample_i       <= s;
    waited = 0;
    @(negedge clk_i);
    while (!sample_ready_o) begin
      waited++;
      if (waited > WaitLimit) begin
        abort_run("timeout: sample_ready_o stayed low and no sample was taken");
      end
      @(negedge clk_i);
    end
    record_accept(s);
    @(posedge clk_i);
  endtask

  task automatic run_burst(input int count, input int max_gap, input bit ramp);
    sample_t s;
    int      gap;
    @(posedge clk_i);
    for (int n = 0; n < count; n++) begin
      s = ramp ? sample_t'(n + 1) : sample_t'($random(seed));
      send_sample(s);
      gap = (max_gap > 0) ? int'($unsigned($random(seed)) % (max_gap + 1)) : 0;
      if (gap > 0) begin
        sample_valid_i <= 1'b0;
        repeat (gap) @(posedge clk_i);
      end
    end
    sample_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) begin
        abort_run("timeout: expected results never came out of the filter");
      end
    end
  endtask

  // Outputs are sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (sample_valid_i && !sample_ready_o) begin
        saw_stall = 1'b1;
      end
      if (result_valid_o) begin
        if (expected_q.size() == 0) begin
          abort_run("result_valid_o pulsed while no result was expected");
        end else begin
          exp_res = expected_q.pop_front();
          check_acc("result_o.y", result_o.y, exp_res.y);
          check_sample("result_o.oldest", result_o.oldest, exp_res.oldest);
          check_seq("result_o.seq", result_o.seq, exp_res.seq);
        end
      end
    end
  end

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    sample_valid_i = 1'b0;
    sample_i       = '0;
    coef_we_i      = 1'b0;
    coef_addr_i    = '0;
    coef_data_i    = '0;
    saw_stall      = 1'b0;
    next_seq       = '0;
    for (int i = 0; i < NumTaps; i++) begin
      hist[i]  = '0;
      coefs[i] = '0;
    end
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    if (!sample_ready_o || result_valid_o) begin
      abort_run("sample_ready_o or result_valid_o has the wrong value after reset");
    end

    // Unit taps on a ramp, first outputs still see the cleared history
    load_all_coefs(1'b1);
    run_burst(24, 2, 1'b1);
    wait_drain();

    // Random taps and data
    load_all_coefs(1'b0);
    run_burst(200, 3, 1'b0);
    wait_drain();

    // Valid held high so credits run out
    saw_stall = 1'b0;
    run_burst(24, 0, 1'b0);
    wait_drain();
    if (!saw_stall) begin
      abort_run("sample_ready_o never fell while sample_valid_i was held high");
    end

    // Random gaps, tag counter wraps past 255 here
    run_burst(100, 6, 1'b0);
    wait_drain();

    // New taps, history kept from the bursts before
    load_all_coefs(1'b0);
    run_burst(40, 2, 1'b0);
    wait_drain();

    repeat (5) @(posedge clk_i);
    if (expected_q.size() != 0) begin
      abort_run("expected results still pending at the end of the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/fir_pkg.sv
hw/fir_dpram.sv
hw/fir_sample_source.sv
hw/fir_sample_fifo.sv
hw/fir_mac_engine.sv
hw/fir_top.sv
tests/tb_fir_top.sv

// ==== Bender.yml ====
package:
  name: fir_stream

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/fir_pkg.sv
      - hw/fir_dpram.sv
      - hw/fir_sample_source.sv
      - hw/fir_sample_fifo.sv
      - hw/fir_mac_engine.sv
      - hw/fir_top.sv
  - target: test
    files:
      - tests/tb_fir_top.sv
